/* cache_subsystem.f */
hw/cache_pkg.sv
hw/generic_bus_if.sv
hw/cache_control_if.sv
hw/direct_mapped_cache.sv
hw/cache_maint_ctrl.sv
hw/separate_caches.sv
hw/cache_subsystem.sv
dv/tb_shared_mem.sv
dv/cache_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := cache_subsystem_tb
FILELIST  := cache_subsystem.f
VFLAGS    := --binary --timing -j 0
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* dv/cache_subsystem_tb.sv */
`timescale 1ns/1ps

module cache_subsystem_tb;
    import cache_pkg::*;

    localparam int TIMEOUT      = 200;
    localparam int MEM_WORDS    = 256;
    // four times the 16-word data cache.
    localparam int DATA_WORDS   = 64;
    localparam int SAMPLE_DELAY = 3;

    logic     CLK;
    logic     arst_n;
    word_t    i_addr;
    logic     i_ren;
    word_t    i_rdata;
    logic     i_busy;
    word_t    d_addr;
    word_t    d_wdata;
    logic     d_ren;
    logic     d_wen;
    byte_en_t d_byte_en;
    word_t    d_rdata;
    logic     d_busy;
    word_t    imem_addr;
    word_t    imem_wdata;
    logic     imem_ren;
    logic     imem_wen;
    byte_en_t imem_byte_en;
    word_t    imem_rdata;
    logic     imem_busy;
    word_t    dmem_addr;
    word_t    dmem_wdata;
    logic     dmem_ren;
    logic     dmem_wen;
    byte_en_t dmem_byte_en;
    word_t    dmem_rdata;
    logic     dmem_busy;
    logic     fence_i;
    logic     maint_busy;
    logic     fence_done;
    logic     icache_miss;
    logic     dcache_miss;

    // memory contents as the processor should see them.
    word_t shadow [MEM_WORDS];

    cache_subsystem #(
        .ICACHE_TYPE(DIRECT_MAPPED),
        .DCACHE_TYPE(DIRECT_MAPPED),
        .ICACHE_SETS(16),
        .DCACHE_SETS(16)
    ) cache_subsystem_inst (
        .CLK(CLK), .arst_n(arst_n),
        .i_addr(i_addr), .i_ren(i_ren), .i_rdata(i_rdata), .i_busy(i_busy),
        .d_addr(d_addr), .d_wdata(d_wdata), .d_ren(d_ren), .d_wen(d_wen),
        .d_byte_en(d_byte_en), .d_rdata(d_rdata), .d_busy(d_busy),
        .imem_addr(imem_addr), .imem_wdata(imem_wdata), .imem_ren(imem_ren),
        .imem_wen(imem_wen), .imem_byte_en(imem_byte_en), .imem_rdata(imem_rdata),
        .imem_busy(imem_busy),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_ren(dmem_ren),
        .dmem_wen(dmem_wen), .dmem_byte_en(dmem_byte_en), .dmem_rdata(dmem_rdata),
        .dmem_busy(dmem_busy),
        .fence_i(fence_i), .maint_busy(maint_busy), .fence_done(fence_done),
        .icache_miss(icache_miss), .dcache_miss(dcache_miss)
    );

    tb_shared_mem #(
        .DEPTH(MEM_WORDS)
    ) mem_inst (
        .CLK(CLK), .arst_n(arst_n),
        .a_addr(imem_addr), .a_wdata(imem_wdata), .a_ren(imem_ren), .a_wen(imem_wen),
        .a_byte_en(imem_byte_en), .a_rdata(imem_rdata), .a_busy(imem_busy),
        .b_addr(dmem_addr), .b_wdata(dmem_wdata), .b_ren(dmem_ren), .b_wen(dmem_wen),
        .b_byte_en(dmem_byte_en), .b_rdata(dmem_rdata), .b_busy(dmem_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    function automatic word_t expected_word(word_t addr);
        return shadow[addr[9:2]];
    endfunction

    // byte lanes of a store land in the shadow image.
    function automatic void store_shadow(word_t addr, word_t data, byte_en_t be);
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (be[b]) begin
                shadow[addr[9:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_quiet();
        check("i_busy", {31'b0, i_busy}, 32'h0);
        check("d_busy", {31'b0, d_busy}, 32'h0);
        check("imem_ren", {31'b0, imem_ren}, 32'h0);
        check("imem_wen", {31'b0, imem_wen}, 32'h0);
        check("dmem_ren", {31'b0, dmem_ren}, 32'h0);
        check("dmem_wen", {31'b0, dmem_wen}, 32'h0);
        check("maint_busy", {31'b0, maint_busy}, 32'h0);
        check("fence_done", {31'b0, fence_done}, 32'h0);
    endtask

    // outputs are sampled just before the rising edge.
    task automatic fetch(input word_t addr, output word_t data, output logic used_mem);
        int   cycles;
        logic done;
        logic saw_miss;
        cycles   = 0;
        done     = 1'b0;
        used_mem = 1'b0;
        saw_miss = 1'b0;
        @(negedge CLK);
        i_addr = addr;
        i_ren  = 1'b1;
        while (!done) begin
            #SAMPLE_DELAY;
            used_mem = used_mem | imem_ren;
            saw_miss = saw_miss | icache_miss;
            if (!i_busy) begin
                data = i_rdata;
                done = 1'b1;
            end
            @(negedge CLK);
            cycles++;
            if (!done && cycles >= TIMEOUT) begin
                timeout_fail("i_busy to fall");
            end
        end
        i_ren = 1'b0;
        // only a fetch that went to memory may raise the miss flag.
        check("icache_miss", {31'b0, saw_miss}, {31'b0, used_mem});
    endtask

    task automatic data_access(input word_t addr, input logic write, input word_t wdata,
                               input byte_en_t be, output word_t rdata);
        int   cycles;
        logic done;
        logic used_mem;
        logic saw_miss;
        cycles   = 0;
        done     = 1'b0;
        used_mem = 1'b0;
        saw_miss = 1'b0;
        @(negedge CLK);
        d_addr    = addr;
        d_wdata   = wdata;
        d_byte_en = be;
        d_wen     = write;
        d_ren     = !write;
        while (!done) begin
            #SAMPLE_DELAY;
            used_mem = used_mem | dmem_ren | dmem_wen;
            saw_miss = saw_miss | dcache_miss;
            if (!d_busy) begin
                rdata = d_rdata;
                done  = 1'b1;
            end
            @(negedge CLK);
            cycles++;
            if (!done && cycles >= TIMEOUT) begin
                timeout_fail("d_busy to fall");
            end
        end
        d_ren = 1'b0;
        d_wen = 1'b0;
        // a miss is flagged exactly when memory was used.
        check("dcache_miss", {31'b0, saw_miss}, {31'b0, used_mem});
    endtask

    task automatic run_fence();
        int cycles;
        @(negedge CLK);
        fence_i = 1'b1;
        @(negedge CLK);
        fence_i = 1'b0;
        #SAMPLE_DELAY;
        check("maint_busy", {31'b0, maint_busy}, 32'h1);
        cycles = 0;
        while (!fence_done) begin
            @(negedge CLK);
            #SAMPLE_DELAY;
            cycles++;
            if (cycles >= TIMEOUT) begin
                timeout_fail("fence_done");
            end
        end
        cycles = 0;
        while (maint_busy) begin
            @(negedge CLK);
            #SAMPLE_DELAY;
            cycles++;
            if (cycles >= TIMEOUT) begin
                timeout_fail("maint_busy to fall");
            end
        end
    endtask

    initial begin
        word_t    addr;
        word_t    data;
        word_t    wdata;
        byte_en_t be;
        logic     write;
        logic     used_mem;
        void'($urandom(32'h544778e1));
        arst_n    = 1'b0;
        i_addr    = '0;
        i_ren     = 1'b0;
        d_addr    = '0;
        d_wdata   = '0;
        d_ren     = 1'b0;
        d_wen     = 1'b0;
        d_byte_en = '0;
        fence_i   = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = word_t'(i) * 32'h0101_0101 + 32'h0000_0100;
        end

        repeat (10) begin
            @(negedge CLK);
            #SAMPLE_DELAY;
            check_quiet();
        end
        @(negedge CLK);
        arst_n = 1'b1;
        #SAMPLE_DELAY;
        check_quiet();

        // fetches, each repeated at once so the second one hits.
        for (int n = 0; n < 40; n++) begin
            addr = word_t'($urandom_range(MEM_WORDS - 1, 0)) << 2;
            fetch(addr, data, used_mem);
            check("i_rdata", data, expected_word(addr));
            fetch(addr, data, used_mem);
            check("i_rdata", data, expected_word(addr));
            check("imem_ren", {31'b0, used_mem}, 32'h0);
        end

        // random loads and stores over four times the cache size.
        for (int n = 0; n < 300; n++) begin
            addr  = word_t'($urandom_range(DATA_WORDS - 1, 0)) << 2;
            write = 1'($urandom_range(1, 0));
            wdata = $urandom;
            be    = 4'($urandom_range(15, 1));
            data_access(addr, write, wdata, be, data);
            if (write) begin
                store_shadow(addr, wdata, be);
            end else begin
                check("d_rdata", data, expected_word(addr));
            end
        end

        // the flush must leave memory equal to the shadow image.
        run_fence();
        for (int i = 0; i < MEM_WORDS; i++) begin
            check($sformatf("mem[%0d]", i), mem_inst.mem[i], shadow[i]);
        end

        // stale instruction line must be dropped by fence_i.
        addr = word_t'($urandom_range(DATA_WORDS - 1, 0)) << 2;
        fetch(addr, data, used_mem);
        check("i_rdata", data, expected_word(addr));
        wdata = ~expected_word(addr);
        data_access(addr, 1'b1, wdata, 4'hF, data);
        store_shadow(addr, wdata, 4'hF);
        run_fence();
        fetch(addr, data, used_mem);
        check("i_rdata", data, expected_word(addr));

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* dv/tb_shared_mem.sv */
`timescale 1ns/1ps

module tb_shared_mem #(
    parameter int DEPTH = 256
) (
    input  logic                CLK,
    input  logic                arst_n,
    // port a, instruction side.
    input  cache_pkg::word_t    a_addr,
    input  cache_pkg::word_t    a_wdata,
    input  logic                a_ren,
    input  logic                a_wen,
    input  cache_pkg::byte_en_t a_byte_en,
    output cache_pkg::word_t    a_rdata,
    output logic                a_busy,
    // port b, data side.
    input  cache_pkg::word_t    b_addr,
    input  cache_pkg::word_t    b_wdata,
    input  logic                b_ren,
    input  logic                b_wen,
    input  cache_pkg::byte_en_t b_byte_en,
    output cache_pkg::word_t    b_rdata,
    output logic                b_busy
);
    import cache_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    word_t            mem [DEPTH];
    logic [IDX_W-1:0] a_idx;
    logic [IDX_W-1:0] b_idx;
    logic             a_req;
    logic             b_req;
    // stall cycles still owed to the pending request of each port.
    logic [1:0]       a_stall;
    logic [1:0]       b_stall;

    assign a_idx   = a_addr[OFFSET_W +: IDX_W];
    assign b_idx   = b_addr[OFFSET_W +: IDX_W];
    assign a_req   = a_ren || a_wen;
    assign b_req   = b_ren || b_wen;
    assign a_busy  = a_req && (a_stall != 2'd0);
    assign b_busy  = b_req && (b_stall != 2'd0);
    assign a_rdata = mem[a_idx];
    assign b_rdata = mem[b_idx];

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            a_stall <= 2'd0;
            b_stall <= 2'd0;
            // preload image, one distinct word per address.
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= word_t'(i) * 32'h0101_0101 + 32'h0000_0100;
            end
        end else begin
            if (a_req) begin
                if (a_stall != 2'd0) begin
                    a_stall <= a_stall - 2'd1;
                end else begin
                    a_stall <= 2'($urandom_range(3, 0));
                end
            end
            if (b_req) begin
                if (b_stall != 2'd0) begin
                    b_stall <= b_stall - 2'd1;
                end else begin
                    b_stall <= 2'($urandom_range(3, 0));
                end
            end
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (a_wen && !a_busy && a_byte_en[b]) begin
                    mem[a_idx][8*b +: 8] <= a_wdata[8*b +: 8];
                end
                if (b_wen && !b_busy && b_byte_en[b]) begin
                    mem[b_idx][8*b +: 8] <= b_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* hw/cache_subsystem.sv */
`timescale 1ns/1ps

module cache_subsystem #(
    parameter cache_pkg::cache_kind_e ICACHE_TYPE = cache_pkg::DIRECT_MAPPED,
    parameter cache_pkg::cache_kind_e DCACHE_TYPE = cache_pkg::DIRECT_MAPPED,
    parameter int                     ICACHE_SETS = 16,
    parameter int                     DCACHE_SETS = 16
) (
    input  logic              CLK,
    input  logic              arst_n,
    // instruction fetch port.
    input  cache_pkg::word_t  i_addr,
    input  logic              i_ren,
    output cache_pkg::word_t  i_rdata,
    output logic              i_busy,
    // data load/store port.
    input  cache_pkg::word_t  d_addr,
    input  cache_pkg::word_t  d_wdata,
    input  logic              d_ren,
    input  logic              d_wen,
    input  cache_pkg::byte_en_t d_byte_en,
    output cache_pkg::word_t  d_rdata,
    output logic              d_busy,
    // instruction memory port.
    output cache_pkg::word_t  imem_addr,
    output cache_pkg::word_t  imem_wdata,
    output logic              imem_ren,
    output logic              imem_wen,
    output cache_pkg::byte_en_t imem_byte_en,
    input  cache_pkg::word_t  imem_rdata,
    input  logic              imem_busy,
    // data memory port.
    output cache_pkg::word_t  dmem_addr,
    output cache_pkg::word_t  dmem_wdata,
    output logic              dmem_ren,
    output logic              dmem_wen,
    output cache_pkg::byte_en_t dmem_byte_en,
    input  cache_pkg::word_t  dmem_rdata,
    input  logic              dmem_busy,
    // maintenance.
    input  logic              fence_i,
    output logic              maint_busy,
    output logic              fence_done,
    output logic              icache_miss,
    output logic              dcache_miss
);

    generic_bus_if icache_proc_bus ();
    generic_bus_if dcache_proc_bus ();
    generic_bus_if icache_mem_bus ();
    generic_bus_if dcache_mem_bus ();
    cache_control_if control ();

    // the fetch side only reads whole words.
    assign icache_proc_bus.addr    = i_addr;
    assign icache_proc_bus.wdata   = '0;
    assign icache_proc_bus.ren     = i_ren;
    assign icache_proc_bus.wen     = 1'b0;
    assign icache_proc_bus.byte_en = '1;
    assign i_rdata                 = icache_proc_bus.rdata;
    assign i_busy                  = icache_proc_bus.busy;

    assign dcache_proc_bus.addr    = d_addr;
    assign dcache_proc_bus.wdata   = d_wdata;
    assign dcache_proc_bus.ren     = d_ren;
    assign dcache_proc_bus.wen     = d_wen;
    assign dcache_proc_bus.byte_en = d_byte_en;
    assign d_rdata                 = dcache_proc_bus.rdata;
    assign d_busy                  = dcache_proc_bus.busy;

    assign imem_addr             = icache_mem_bus.addr;
    assign imem_wdata            = icache_mem_bus.wdata;
    assign imem_ren              = icache_mem_bus.ren;
    assign imem_wen              = icache_mem_bus.wen;
    assign imem_byte_en          = icache_mem_bus.byte_en;
    assign icache_mem_bus.rdata  = imem_rdata;
    assign icache_mem_bus.busy   = imem_busy;

    assign dmem_addr             = dcache_mem_bus.addr;
    assign dmem_wdata            = dcache_mem_bus.wdata;
    assign dmem_ren              = dcache_mem_bus.ren;
    assign dmem_wen              = dcache_mem_bus.wen;
    assign dmem_byte_en          = dcache_mem_bus.byte_en;
    assign dcache_mem_bus.rdata  = dmem_rdata;
    assign dcache_mem_bus.busy   = dmem_busy;

    cache_maint_ctrl maint_ctrl (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .fence_i   (fence_i),
        .ctrl      (control.ctrl),
        .maint_busy(maint_busy),
        .fence_done(fence_done)
    );

    separate_caches #(
        .ICACHE_TYPE(ICACHE_TYPE),
        .DCACHE_TYPE(DCACHE_TYPE),
        .ICACHE_SETS(ICACHE_SETS),
        .DCACHE_SETS(DCACHE_SETS)
    ) caches (
        .CLK            (CLK),
        .arst_n         (arst_n),
        .icache_proc_bus(icache_proc_bus.generic_bus),
        .dcache_proc_bus(dcache_proc_bus.generic_bus),
        .icache_mem_bus (icache_mem_bus.cpu),
        .dcache_mem_bus (dcache_mem_bus.cpu),
        .control        (control.caches),
        .icache_miss    (icache_miss),
        .dcache_miss    (dcache_miss)
    );

endmodule

/* hw/separate_caches.sv */
`timescale 1ns/1ps

module separate_caches #(
    parameter cache_pkg::cache_kind_e ICACHE_TYPE = cache_pkg::DIRECT_MAPPED,
    parameter cache_pkg::cache_kind_e DCACHE_TYPE = cache_pkg::DIRECT_MAPPED,
    parameter int                     ICACHE_SETS = 16,
    parameter int                     DCACHE_SETS = 16
) (
    input  logic               CLK,
    input  logic               arst_n,
    generic_bus_if.generic_bus icache_proc_bus,
    generic_bus_if.generic_bus dcache_proc_bus,
    generic_bus_if.cpu         icache_mem_bus,
    generic_bus_if.cpu         dcache_mem_bus,
    cache_control_if.caches    control,
    output logic               icache_miss,
    output logic               dcache_miss
);
    import cache_pkg::*;

    generate
        case (ICACHE_TYPE)
            PASS_THROUGH: begin : g_icache_pass
                assign icache_mem_bus.addr    = icache_proc_bus.addr;
                assign icache_mem_bus.wdata   = icache_proc_bus.wdata;
                assign icache_mem_bus.ren     = icache_proc_bus.ren;
                assign icache_mem_bus.wen     = icache_proc_bus.wen;
                assign icache_mem_bus.byte_en = icache_proc_bus.byte_en;
                assign icache_proc_bus.rdata  = icache_mem_bus.rdata;
                assign icache_proc_bus.busy   = icache_mem_bus.busy;
                assign control.iflush_done    = 1'b1;
                assign control.iclear_done    = 1'b1;
                assign icache_miss            = 1'b0;
            end
            DIRECT_MAPPED: begin : g_icache_dm
                direct_mapped_cache #(
                    .SETS(ICACHE_SETS)
                ) icache (
                    .CLK       (CLK),
                    .arst_n    (arst_n),
                    .proc_bus  (icache_proc_bus),
                    .mem_bus   (icache_mem_bus),
                    .flush     (control.icache_flush),
                    .clear     (control.icache_clear),
                    .flush_done(control.iflush_done),
                    .clear_done(control.iclear_done)
                );
                // busy outside maintenance means the line is being fetched.
                assign icache_miss = icache_proc_bus.busy &&
                                     (icache_proc_bus.ren || icache_proc_bus.wen) &&
                                     !(control.icache_flush || control.icache_clear ||
                                       control.iflush_done || control.iclear_done);
            end
        endcase
    endgenerate

    generate
        case (DCACHE_TYPE)
            PASS_THROUGH: begin : g_dcache_pass
                assign dcache_mem_bus.addr    = dcache_proc_bus.addr;
                assign dcache_mem_bus.wdata   = dcache_proc_bus.wdata;
                assign dcache_mem_bus.ren     = dcache_proc_bus.ren;
                assign dcache_mem_bus.wen     = dcache_proc_bus.wen;
                assign dcache_mem_bus.byte_en = dcache_proc_bus.byte_en;
                assign dcache_proc_bus.rdata  = dcache_mem_bus.rdata;
                assign dcache_proc_bus.busy   = dcache_mem_bus.busy;
                assign control.dflush_done    = 1'b1;
                assign control.dclear_done    = 1'b1;
                assign dcache_miss            = 1'b0;
            end
            DIRECT_MAPPED: begin : g_dcache_dm
                direct_mapped_cache #(
                    .SETS(DCACHE_SETS)
                ) dcache (
                    .CLK       (CLK),
                    .arst_n    (arst_n),
                    .proc_bus  (dcache_proc_bus),
                    .mem_bus   (dcache_mem_bus),
                    .flush     (control.dcache_flush),
                    .clear     (control.dcache_clear),
                    .flush_done(control.dflush_done),
                    .clear_done(control.dclear_done)
                );
                assign dcache_miss = dcache_proc_bus.busy &&
                                     (dcache_proc_bus.ren || dcache_proc_bus.wen) &&
                                     !(control.dcache_flush || control.dcache_clear ||
                                       control.dflush_done || control.dclear_done);
            end
        endcase
    endgenerate

endmodule

/* hw/cache_maint_ctrl.sv */
`timescale 1ns/1ps

module cache_maint_ctrl (
    input  logic         CLK,
    input  logic         arst_n,
    input  logic         fence_i,
    cache_control_if.ctrl ctrl,
    output logic         maint_busy,
    output logic         fence_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FLUSH_D,
        ST_CLEAR_I,
        ST_FINISH
    } state_e;

    state_e state;
    state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (fence_i) begin
                    state_next = ST_FLUSH_D;
                end
            end
            ST_FLUSH_D: begin
                if (ctrl.dflush_done) begin
                    state_next = ST_CLEAR_I;
                end
            end
            ST_CLEAR_I: begin
                if (ctrl.iclear_done) begin
                    state_next = ST_FINISH;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // dirty data reaches memory before the instruction lines are dropped.
    assign ctrl.dcache_flush = (state == ST_FLUSH_D);
    assign ctrl.icache_clear = (state == ST_CLEAR_I);
    assign ctrl.icache_flush = 1'b0;
    assign ctrl.dcache_clear = 1'b0;

    // fence_i pulses are ignored while a sequence runs.
    assign maint_busy = (state != ST_IDLE);
    assign fence_done = (state == ST_FINISH);

endmodule

/* hw/direct_mapped_cache.sv */
`timescale 1ns/1ps

module direct_mapped_cache #(
    parameter int SETS = 16
) (
    input  logic               CLK,
    input  logic               arst_n,
    generic_bus_if.generic_bus proc_bus,
    generic_bus_if.cpu         mem_bus,
    input  logic               flush,
    input  logic               clear,
    output logic               flush_done,
    output logic               clear_done
);
    import cache_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = WORD_W - OFFSET_W - IDX_W;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE_BACK,
        ST_FILL,
        ST_FLUSH_WALK,
        ST_CLEAR_WALK,
        ST_DONE
    } state_e;

    state_e state;
    state_e state_next;

    // per-set line state.
    logic [SETS-1:0]  valid;
    logic [SETS-1:0]  dirty;
    logic [TAG_W-1:0] tag_arr [SETS];
    word_t            data_arr [SETS];

    logic [IDX_W-1:0] walk_idx;
    // set when the done state closes a flush rather than a clear.
    logic             walk_flush;

    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] sel_idx;
    logic             req;
    logic             maint;
    logic             hit;
    logic             victim_dirty;
    logic             mem_done;
    logic             walk_wb;
    logic             walk_step;
    logic             last_set;
    logic             wr_hit;
    logic             fill_done;
    word_t            fill_word;

    function automatic word_t merge_bytes(word_t old_word, word_t new_word, byte_en_t be);
        word_t result;
        result = old_word;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // address split after the byte offset.
    assign req_idx = proc_bus.addr[OFFSET_W +: IDX_W];
    assign req_tag = proc_bus.addr[WORD_W-1 -: TAG_W];

    assign req          = proc_bus.ren || proc_bus.wen;
    assign maint        = flush || clear;
    assign hit          = valid[req_idx] && (tag_arr[req_idx] == req_tag);
    assign victim_dirty = valid[req_idx] && dirty[req_idx];
    assign mem_done     = !mem_bus.busy;

    assign walk_wb   = valid[walk_idx] && dirty[walk_idx];
    assign walk_step = (state == ST_CLEAR_WALK) ||
                       ((state == ST_FLUSH_WALK) && (!walk_wb || mem_done));
    assign last_set  = (walk_idx == IDX_W'(SETS - 1));

    assign wr_hit    = (state == ST_IDLE) && !maint && proc_bus.wen && hit;
    assign fill_done = (state == ST_FILL) && mem_done;

    // a write miss merges its bytes into the word that comes back.
    assign fill_word = proc_bus.wen ?
                       merge_bytes(mem_bus.rdata, proc_bus.wdata, proc_bus.byte_en) :
                       mem_bus.rdata;

    assign sel_idx = (state == ST_FLUSH_WALK) ? walk_idx : req_idx;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (flush) begin
                    state_next = ST_FLUSH_WALK;
                end else if (clear) begin
                    state_next = ST_CLEAR_WALK;
                end else if (req && !hit) begin
                    state_next = victim_dirty ? ST_WRITE_BACK : ST_FILL;
                end
            end
            ST_WRITE_BACK: begin
                if (mem_done) begin
                    state_next = ST_FILL;
                end
            end
            ST_FILL: begin
                if (mem_done) begin
                    state_next = ST_IDLE;
                end
            end
            ST_FLUSH_WALK, ST_CLEAR_WALK: begin
                if (walk_step && last_set) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                // hold done until the request level drops.
                if (walk_flush ? !flush : !clear) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    // memory side requests, held stable while memory is busy.
    always_comb begin
        mem_bus.ren     = (state == ST_FILL);
        mem_bus.wen     = (state == ST_WRITE_BACK) || ((state == ST_FLUSH_WALK) && walk_wb);
        mem_bus.byte_en = '1;
        mem_bus.wdata   = data_arr[sel_idx];
        if (state == ST_FILL) begin
            mem_bus.addr = {proc_bus.addr[WORD_W-1:OFFSET_W], OFFSET_W'(0)};
        end else begin
            mem_bus.addr = {tag_arr[sel_idx], sel_idx, OFFSET_W'(0)};
        end
    end

    // hits answer in the request cycle, misses when the fill completes.
    always_comb begin
        proc_bus.rdata = data_arr[req_idx];
        case (state)
            ST_IDLE: proc_bus.busy = req && (maint || !hit);
            ST_FILL: begin
                proc_bus.busy  = mem_bus.busy;
                proc_bus.rdata = mem_bus.rdata;
            end
            default: proc_bus.busy = 1'b1;
        endcase
    end

    assign flush_done = (state == ST_DONE) && walk_flush;
    assign clear_done = (state == ST_DONE) && !walk_flush;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            valid      <= '0;
            dirty      <= '0;
            walk_idx   <= '0;
            walk_flush <= 1'b0;
        end else begin
            state <= state_next;
            if (state == ST_IDLE) begin
                walk_idx   <= '0;
                walk_flush <= flush;
            end else if (walk_step && !last_set) begin
                walk_idx <= walk_idx + 1'b1;
            end

            if (wr_hit) begin
                dirty[req_idx] <= 1'b1;
            end
            if (fill_done) begin
                valid[req_idx] <= 1'b1;
                dirty[req_idx] <= proc_bus.wen;
            end
            if ((state == ST_FLUSH_WALK) && walk_wb && mem_done) begin
                dirty[walk_idx] <= 1'b0;
            end
            // clear drops the line along with any dirty data.
            if (state == ST_CLEAR_WALK) begin
                valid[walk_idx] <= 1'b0;
                dirty[walk_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_hit) begin
            data_arr[req_idx] <= merge_bytes(data_arr[req_idx], proc_bus.wdata, proc_bus.byte_en);
        end else if (fill_done) begin
            data_arr[req_idx] <= fill_word;
            tag_arr[req_idx]  <= req_tag;
        end
    end

endmodule

/* hw/cache_control_if.sv */
`timescale 1ns/1ps

interface cache_control_if;

    logic icache_flush;
    logic icache_clear;
    logic dcache_flush;
    logic dcache_clear;
    logic iflush_done;
    logic iclear_done;
    logic dflush_done;
    logic dclear_done;

    // the caches answer each request level with its done level.
    modport caches (
        input  icache_flush,
        input  icache_clear,
        input  dcache_flush,
        input  dcache_clear,
        output iflush_done,
        output iclear_done,
        output dflush_done,
        output dclear_done
    );

    modport ctrl (
        output icache_flush,
        output icache_clear,
        output dcache_flush,
        output dcache_clear,
        input  iflush_done,
        input  iclear_done,
        input  dflush_done,
        input  dclear_done
    );

endinterface

/* hw/generic_bus_if.sv */
`timescale 1ns/1ps

interface generic_bus_if;
    import cache_pkg::*;

    word_t    addr;
    word_t    wdata;
    word_t    rdata;
    logic     ren;
    logic     wen;
    byte_en_t byte_en;
    logic     busy;

    // requester side.
    modport cpu (
        output addr,
        output wdata,
        output ren,
        output wen,
        output byte_en,
        input  rdata,
        input  busy
    );

    // responder side.
    modport generic_bus (
        input  addr,
        input  wdata,
        input  ren,
        input  wen,
        input  byte_en,
        output rdata,
        output busy
    );

endinterface

/* hw/cache_pkg.sv */
package cache_pkg;

    // bus word and byte-lane sizes.
    localparam int WORD_W = 32;
    localparam int BYTES_PER_WORD = WORD_W / 8;

    // low address bits that select a byte inside a word.
    localparam int OFFSET_W = $clog2(BYTES_PER_WORD);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

    // cache variant chosen per side at elaboration time.
    typedef enum logic [1:0] {
        PASS_THROUGH,
        DIRECT_MAPPED
    } cache_kind_e;

endpackage
